//--- hdl/pipe_pkg.sv
package pipe_pkg;

    localparam int ADDR_W = 30;
    localparam int REG_W  = 4;
    localparam int CNT_W  = 16;

    // Unlisted codes pass through execute as no-ops
    typedef enum logic [3:0] {
        OP_ADD    = 4'h0,
        OP_SUB    = 4'h1,
        OP_AND    = 4'h2,
        OP_OR     = 4'h3,
        OP_XOR    = 4'h4,
        OP_ADDI   = 4'h5,
        OP_EBREAK = 4'hf
    } opcode_e;

    // Raw instruction word as returned by the icache
    typedef struct packed {
        logic [3:0]       opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [15:0]      imm;
    } instr_t;

    // Buffer entry after decode
    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        opcode_e           op;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs1;
        logic [REG_W-1:0]  rs2;
        logic [31:0]       imm;
    } decoded_t;

    // One record per retired ALU instruction
    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [REG_W-1:0]  rd;
        logic [31:0]       data;
    } commit_t;

endpackage

//--- hdl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
    parameter logic [pipe_pkg::ADDR_W-1:0] START_PC = '0,
    parameter int IBUF_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                reset,

    // Icache request
    output logic                                icache_req_valid,
    output logic [pipe_pkg::ADDR_W-1:0]         icache_req_addr,
    input  logic                                icache_req_ready,

    // Icache response, in request order
    input  logic                                icache_rsp_valid,
    input  logic [31:0]                         icache_rsp_data,

    input  logic [$clog2(IBUF_DEPTH+1)-1:0]     space,
    input  logic                                halt,

    output logic                                wr_valid,
    output logic [pipe_pkg::ADDR_W-1:0]         wr_pc,
    output pipe_pkg::instr_t                    wr_data,
    output logic                                outstanding_any
);
    localparam int CW = $clog2(IBUF_DEPTH + 1);

    logic                        valid_q;
    logic [pipe_pkg::ADDR_W-1:0] req_pc;
    logic [pipe_pkg::ADDR_W-1:0] rsp_pc;
    logic [CW-1:0]               outstanding;
    logic [CW:0]                 credit_used;
    logic                        req_fire;

    assign icache_req_valid = valid_q && !halt;
    assign icache_req_addr  = req_pc;
    assign req_fire         = icache_req_valid && icache_req_ready;

    // Slots taken once this cycle's transfer is counted
    assign credit_used = {1'b0, outstanding} + {{CW{1'b0}}, req_fire};

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q     <= 1'b0;
            req_pc      <= START_PC;
            rsp_pc      <= START_PC;
            outstanding <= '0;
        end else begin
            if (halt) begin
                valid_q <= 1'b0;
            end else if (!valid_q || icache_req_ready) begin
                valid_q <= credit_used < {1'b0, space};
            end
            if (req_fire) begin
                req_pc <= req_pc + 1'b1;
            end
            if (icache_rsp_valid) begin
                rsp_pc <= rsp_pc + 1'b1;
            end
            case ({req_fire, icache_rsp_valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // Responses after halt are counted above but dropped here
    assign wr_valid        = icache_rsp_valid && !halt;
    assign wr_pc           = rsp_pc;
    assign wr_data         = pipe_pkg::instr_t'(icache_rsp_data);
    assign outstanding_any = outstanding != '0;

endmodule

//--- hdl/decode_buffer.sv
`timescale 1ns/1ns

module decode_buffer #(
    parameter int IBUF_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                wr_valid,
    input  logic [pipe_pkg::ADDR_W-1:0]         wr_pc,
    input  pipe_pkg::instr_t                    wr_data,

    output logic                                out_valid,
    output pipe_pkg::decoded_t                  out,
    input  logic                                pop_ready,

    input  logic                                halt,
    output logic [$clog2(IBUF_DEPTH+1)-1:0]     space
);
    localparam int CW = $clog2(IBUF_DEPTH + 1);
    localparam int PW = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;

    pipe_pkg::decoded_t entries [IBUF_DEPTH];
    pipe_pkg::decoded_t wr_dec;
    logic [PW-1:0]      wr_ptr;
    logic [PW-1:0]      rd_ptr;
    logic [CW-1:0]      count;
    logic               push;
    logic               pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(IBUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        wr_dec.pc  = wr_pc;
        wr_dec.op  = pipe_pkg::opcode_e'(wr_data.opcode);
        wr_dec.rd  = wr_data.rd;
        wr_dec.rs1 = wr_data.rs1;
        wr_dec.rs2 = wr_data.rs2;
        wr_dec.imm = {{16{wr_data.imm[15]}}, wr_data.imm};
    end

    assign push      = wr_valid && !halt;
    assign pop       = out_valid && pop_ready;
    assign out_valid = count != '0;
    assign out       = entries[rd_ptr];
    assign space     = CW'(IBUF_DEPTH) - count;

    // Halt drops whatever is still queued
    always_ff @(posedge clk) begin
        if (reset || halt) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= wr_dec;
        end
    end

endmodule

//--- hdl/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
    input  logic                clk,
    input  logic                reset,

    // Decode buffer head
    input  logic                out_valid,
    input  pipe_pkg::decoded_t  out,
    output logic                pop_ready,

    // Commit output
    output logic                commit_valid,
    output pipe_pkg::commit_t   commit,
    input  logic                commit_ready,

    output logic                ebreak,
    output logic                halt
);
    localparam int NUM_REGS = 2 ** pipe_pkg::REG_W;

    logic [31:0] regs [NUM_REGS];
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] operand_b;
    logic [31:0] result;
    logic        is_alu;
    logic        is_ebreak;
    logic        pop;

    // Register 0 is never written, so it reads as zero
    assign rs1_val = regs[out.rs1];
    assign rs2_val = regs[out.rs2];

    always_comb begin
        operand_b = (out.op == pipe_pkg::OP_ADDI) ? out.imm : rs2_val;
        is_alu    = 1'b1;
        case (out.op)
            pipe_pkg::OP_ADD:  result = rs1_val + operand_b;
            pipe_pkg::OP_SUB:  result = rs1_val - operand_b;
            pipe_pkg::OP_AND:  result = rs1_val & operand_b;
            pipe_pkg::OP_OR:   result = rs1_val | operand_b;
            pipe_pkg::OP_XOR:  result = rs1_val ^ operand_b;
            pipe_pkg::OP_ADDI: result = rs1_val + operand_b;
            default: begin
                result = '0;
                is_alu = 1'b0;
            end
        endcase
    end

    assign is_ebreak = out.op == pipe_pkg::OP_EBREAK;

    // Take a new entry only if the commit slot frees up this cycle
    assign pop_ready = !halt && (!commit_valid || commit_ready);
    assign pop       = out_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            ebreak       <= 1'b0;
            halt         <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            ebreak <= pop && is_ebreak;
            if (pop && is_ebreak) begin
                halt <= 1'b1;
            end
            if (pop && is_alu) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
            if (pop && is_alu && out.rd != '0) begin
                regs[out.rd] <= result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop && is_alu) begin
            commit.pc   <= out.pc;
            commit.rd   <= out.rd;
            commit.data <= result;
        end
    end

endmodule

//--- hdl/pipeline_top.sv
`timescale 1ns/1ns

module pipeline_top #(
    parameter int IBUF_DEPTH = 4,
    parameter logic [pipe_pkg::ADDR_W-1:0] START_PC = '0
) (
    input  logic                            clk,
    input  logic                            reset,

    // Icache request
    output logic                            icache_req_valid,
    output logic [pipe_pkg::ADDR_W-1:0]     icache_req_addr,
    input  logic                            icache_req_ready,

    // Icache response
    input  logic                            icache_rsp_valid,
    input  logic [31:0]                     icache_rsp_data,

    // Commit
    output logic                            commit_valid,
    output pipe_pkg::commit_t               commit,
    input  logic                            commit_ready,

    // Status
    output logic                            busy,
    output logic                            ebreak,
    output logic [pipe_pkg::CNT_W-1:0]      icache_stalls,
    output logic [pipe_pkg::CNT_W-1:0]      buffer_stalls
);
    localparam int SW = $clog2(IBUF_DEPTH + 1);

    logic                        wr_valid;
    logic [pipe_pkg::ADDR_W-1:0] wr_pc;
    pipe_pkg::instr_t            wr_data;
    logic [SW-1:0]               space;
    logic                        out_valid;
    pipe_pkg::decoded_t          out;
    logic                        pop_ready;
    logic                        halt;
    logic                        outstanding_any;
    logic [1:0]                  stall_cond;
    logic [pipe_pkg::CNT_W-1:0]  stall_cnt [2];

    fetch_unit #(
        .START_PC   (START_PC),
        .IBUF_DEPTH (IBUF_DEPTH)
    ) fetch_i (
        .clk              (clk),
        .reset            (reset),
        .icache_req_valid (icache_req_valid),
        .icache_req_addr  (icache_req_addr),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_data  (icache_rsp_data),
        .space            (space),
        .halt             (halt),
        .wr_valid         (wr_valid),
        .wr_pc            (wr_pc),
        .wr_data          (wr_data),
        .outstanding_any  (outstanding_any)
    );

    decode_buffer #(
        .IBUF_DEPTH (IBUF_DEPTH)
    ) buffer_i (
        .clk       (clk),
        .reset     (reset),
        .wr_valid  (wr_valid),
        .wr_pc     (wr_pc),
        .wr_data   (wr_data),
        .out_valid (out_valid),
        .out       (out),
        .pop_ready (pop_ready),
        .halt      (halt),
        .space     (space)
    );

    execute_unit execute_i (
        .clk          (clk),
        .reset        (reset),
        .out_valid    (out_valid),
        .out          (out),
        .pop_ready    (pop_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready),
        .ebreak       (ebreak),
        .halt         (halt)
    );

    // Index 0 is the icache stall, index 1 the buffer stall
    assign stall_cond = {out_valid && !pop_ready, icache_req_valid && !icache_req_ready};

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_cnt[0] <= '0;
            stall_cnt[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (stall_cond[i] && stall_cnt[i] != '1) begin
                    stall_cnt[i] <= stall_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign icache_stalls = stall_cnt[0];
    assign buffer_stalls = stall_cnt[1];

    // Idle once halted with nothing in flight and the last commit taken
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= !(halt && !outstanding_any && !commit_valid);
        end
    end

endmodule

//--- bench/pipeline_properties.sv
`timescale 1ns/1ns

module pipeline_properties (
    input logic                          clk,
    input logic                          reset,
    input logic                          icache_req_valid,
    input logic                          icache_req_ready,
    input logic [pipe_pkg::ADDR_W-1:0]   icache_req_addr,
    input logic                          commit_valid,
    input logic                          commit_ready,
    input pipe_pkg::commit_t             commit,
    input logic                          ebreak,
    input logic                          halt
);

    int fail_count = 0;

    // Halt may withdraw a stalled request
    req_hold: assert property (@(posedge clk) disable iff (reset)
        icache_req_valid && !icache_req_ready && !halt
        |=> halt || (icache_req_valid && $stable(icache_req_addr)))
        else begin
            $error("icache request changed while stalled");
            fail_count++;
        end

    commit_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else begin
            $error("commit record changed while stalled");
            fail_count++;
        end

    ebreak_pulse: assert property (@(posedge clk) disable iff (reset)
        ebreak |=> !ebreak)
        else begin
            $error("ebreak lasted more than one cycle");
            fail_count++;
        end

    // Halt stays set and keeps the request port quiet
    no_req_halted: assert property (@(posedge clk) disable iff (reset)
        halt |=> halt && !icache_req_valid)
        else begin
            $error("halt dropped or icache request raised while halted");
            fail_count++;
        end

endmodule

bind pipeline_top pipeline_properties props_i (
    .clk              (clk),
    .reset            (reset),
    .icache_req_valid (icache_req_valid),
    .icache_req_ready (icache_req_ready),
    .icache_req_addr  (icache_req_addr),
    .commit_valid     (commit_valid),
    .commit_ready     (commit_ready),
    .commit           (commit),
    .ebreak           (ebreak),
    .halt             (halt)
);

//--- bench/pipeline_tb.sv
`timescale 1ns/1ns

module pipeline_tb;
    localparam int IBUF_DEPTH = 4;
    localparam int PROG_LEN   = 40;
    localparam int ADDR_W     = pipe_pkg::ADDR_W;
    localparam int CNT_W      = pipe_pkg::CNT_W;

    logic                clk;
    logic                reset;
    logic                icache_req_valid;
    logic [ADDR_W-1:0]   icache_req_addr;
    logic                icache_req_ready;
    logic                icache_rsp_valid;
    logic [31:0]         icache_rsp_data;
    logic                commit_valid;
    pipe_pkg::commit_t   commit;
    logic                commit_ready;
    logic                busy;
    logic                ebreak;
    logic [CNT_W-1:0]    icache_stalls;
    logic [CNT_W-1:0]    buffer_stalls;

    logic [31:0]         lfsr;
    logic [31:0]         prog [PROG_LEN+1];
    pipe_pkg::commit_t   exp_q [$];
    logic [ADDR_W-1:0]   addr_q [$];
    int                  due_q [$];
    int                  cyc;
    int                  last_due;
    int                  errors;
    int                  test_errs [5];
    int                  ebreaks;
    int                  n_commits;
    int                  buf_cnt;
    int                  seen_icache_stalls;
    int                  seen_buffer_stalls;
    logic                halted;
    logic [ADDR_W-1:0]   exp_addr;
    string               test_names [5] = '{"commit order", "fetch addresses", "commit count",
                                            "ebreak and busy", "stall counters"};

    pipeline_top #(
        .IBUF_DEPTH (IBUF_DEPTH),
        .START_PC   ('0)
    ) dut_i (
        .clk              (clk),
        .reset            (reset),
        .icache_req_valid (icache_req_valid),
        .icache_req_addr  (icache_req_addr),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_data  (icache_rsp_data),
        .commit_valid     (commit_valid),
        .commit           (commit),
        .commit_ready     (commit_ready),
        .busy             (busy),
        .ebreak           (ebreak),
        .icache_stalls    (icache_stalls),
        .buffer_stalls    (buffer_stalls)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Past the program the words are no-ops tagged with their address
    function automatic logic [31:0] word_at(input logic [ADDR_W-1:0] addr);
        if (addr <= PROG_LEN) begin
            return prog[addr];
        end
        return {4'he, addr[27:0] ^ {26'h0, addr[29:28]}};
    endfunction

    task automatic note_failure(input int test, input string what);
        $display("%0t: %s", $time, what);
        errors++;
        test_errs[test]++;
    endtask

    task automatic check_commit(input pipe_pkg::commit_t got, input pipe_pkg::commit_t exp);
        if (got !== exp) begin
            $display("Fail %0t commit: got pc=%0h rd=%0d data=%h, expected pc=%0h rd=%0d data=%h",
                     $time, got.pc, got.rd, got.data, exp.pc, exp.rd, exp.data);
            errors++;
            test_errs[0]++;
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail %0t icache_req_addr: got %0h, expected %0h", $time, got, exp);
            errors++;
            test_errs[1]++;
        end
    endtask

    task automatic check_count(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] exp,
                               input string name, input int test);
        if (got !== exp) begin
            $display("Fail %0t %s: got %0d, expected %0d", $time, name, got, exp);
            errors++;
            test_errs[test]++;
        end
    endtask

    // Random ALU program with its expected commits
    task automatic build_program();
        pipe_pkg::instr_t  ins;
        pipe_pkg::commit_t c;
        logic [31:0]       regs [16];
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       res;
        logic [31:0]       r;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            take_bits(3, r);
            ins.opcode = 4'(r % 6);
            take_bits(4, r);
            ins.rd = r[3:0];
            take_bits(4, r);
            ins.rs1 = r[3:0];
            take_bits(4, r);
            ins.rs2 = r[3:0];
            take_bits(16, r);
            ins.imm = r[15:0];
            prog[i] = ins;
            a = regs[ins.rs1];
            b = (ins.opcode == 4'h5) ? {{16{ins.imm[15]}}, ins.imm} : regs[ins.rs2];
            case (ins.opcode)
                4'h0:    res = a + b;
                4'h1:    res = a - b;
                4'h2:    res = a & b;
                4'h3:    res = a | b;
                4'h4:    res = a ^ b;
                default: res = a + b;
            endcase
            if (ins.rd != 4'h0) begin
                regs[ins.rd] = res;
            end
            c.pc   = ADDR_W'(i);
            c.rd   = ins.rd;
            c.data = res;
            exp_q.push_back(c);
        end
        prog[PROG_LEN] = {4'hf, 28'h0};
    endtask

    // One cycle: drive at the falling edge, then look at what the next edge will take
    task automatic step_cycle();
        logic [31:0] r;
        logic        head;
        logic        pop_ok;
        @(negedge clk);
        cyc++;
        if (addr_q.size() > 0 && due_q[0] <= cyc) begin
            icache_rsp_valid = 1'b1;
            icache_rsp_data  = word_at(addr_q.pop_front());
            void'(due_q.pop_front());
        end else begin
            icache_rsp_valid = 1'b0;
            icache_rsp_data  = '0;
        end
        take_bits(2, r);
        icache_req_ready = r[1:0] != 2'b00;
        take_bits(2, r);
        commit_ready = r[1:0] != 2'b00;
        #2;
        if (ebreak) begin
            ebreaks++;
            if (exp_q.size() != 0 || commit_valid) begin
                note_failure(3, "ebreak arrived before the last commit was taken");
            end
        end
        halted = halted || ebreak;
        if (!halted && !busy) begin
            note_failure(3, "busy was low while the program was still running");
        end
        if (icache_req_valid && halted) begin
            note_failure(1, "a request was issued after ebreak");
        end else if (icache_req_valid && icache_req_ready) begin
            check_addr(icache_req_addr, exp_addr);
            exp_addr++;
            take_bits(2, r);
            last_due = (cyc + 1 + int'(r) > last_due + 1) ? cyc + 1 + int'(r) : last_due + 1;
            addr_q.push_back(icache_req_addr);
            due_q.push_back(last_due);
        end
        if (icache_req_valid && !icache_req_ready) begin
            seen_icache_stalls++;
        end
        // Buffer occupancy follows from port activity
        head   = buf_cnt != 0;
        pop_ok = !halted && (!commit_valid || commit_ready);
        if (head && !pop_ok) begin
            seen_buffer_stalls++;
        end
        if (halted) begin
            buf_cnt = 0;
        end else begin
            buf_cnt = buf_cnt + int'(icache_rsp_valid) - int'(head && pop_ok);
        end
        if (commit_valid && commit_ready) begin
            n_commits++;
            if (exp_q.size() == 0) begin
                note_failure(0, "a commit arrived when none was expected");
            end else begin
                check_commit(commit, exp_q.pop_front());
            end
        end
    endtask

    initial begin
        int wait_cycles;
        reset            = 1'b1;
        icache_req_ready = 1'b0;
        icache_rsp_valid = 1'b0;
        icache_rsp_data  = '0;
        commit_ready     = 1'b0;
        lfsr               = 32'd71210;
        cyc                = 0;
        last_due           = 0;
        errors             = 0;
        ebreaks            = 0;
        n_commits          = 0;
        buf_cnt            = 0;
        seen_icache_stalls = 0;
        seen_buffer_stalls = 0;
        halted             = 1'b0;
        exp_addr           = '0;
        for (int t = 0; t < 5; t++) begin
            test_errs[t] = 0;
        end
        build_program();

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        wait_cycles = 0;
        while (ebreaks == 0 && wait_cycles < 3000) begin
            step_cycle();
            wait_cycles++;
        end
        if (ebreaks == 0) begin
            note_failure(3, "Timed out waiting for ebreak");
        end
        wait_cycles = 0;
        while (busy && wait_cycles < 100) begin
            step_cycle();
            wait_cycles++;
        end
        if (busy) begin
            note_failure(3, "Timed out waiting for busy to fall after ebreak");
        end
        // A few idle cycles to catch late requests or a second ebreak
        repeat (5) step_cycle();

        check_count(CNT_W'(n_commits), CNT_W'(PROG_LEN), "commit count", 2);
        if (exp_q.size() != 0) begin
            note_failure(2, "some expected commits never arrived");
        end
        if (ebreaks != 1) begin
            note_failure(3, "ebreak did not pulse exactly once");
        end
        check_count(icache_stalls, CNT_W'(seen_icache_stalls), "icache_stalls", 4);
        check_count(buffer_stalls, CNT_W'(seen_buffer_stalls), "buffer_stalls", 4);
        if (dut_i.props_i.fail_count != 0) begin
            $display("%0t: the bound assertions failed %0d times", $time,
                     dut_i.props_i.fail_count);
            errors += dut_i.props_i.fail_count;
        end
        for (int t = 0; t < 5; t++) begin
            $display("Test %0d %s: %s", t + 1, test_names[t],
                     (test_errs[t] == 0) ? "passed" : "failed");
        end
        $display("Tests run: 5, commits: %0d, errors: %0d", n_commits, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- flist.f
hdl/pipe_pkg.sv
hdl/fetch_unit.sv
hdl/decode_buffer.sv
hdl/execute_unit.sv
hdl/pipeline_top.sv
bench/pipeline_properties.sv
bench/pipeline_tb.sv

//--- Bender.yml
package:
  name: pipeline

sources:
  # RTL, in compile order
  - files:
      - hdl/pipe_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/decode_buffer.sv
      - hdl/execute_unit.sv
      - hdl/pipeline_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/pipeline_properties.sv
      - bench/pipeline_tb.sv
